// ==== rtl/lq_pkg.sv ====
`default_nettype none

package lq_pkg;

    // default sizes, overridden from the top level
    localparam int lq_size_default = 8;
    localparam int sq_size_default = 8;
    localparam int ways_default    = 2;

    // address split into an 8-byte block and a byte offset
    localparam int offset_bits = 3;
    localparam int block_bits  = 13;

    typedef logic [4:0]  rob_idx_t;
    typedef logic [5:0]  prf_idx_t;
    typedef logic [15:0] mem_addr_t;
    typedef logic [31:0] word_t;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } access_size_t;

endpackage

`default_nettype wire

// ==== rtl/rr_arbiter.sv ====
`default_nettype none

module rr_arbiter #(
    parameter  int WIDTH = 8,
    localparam int PTR_W = $clog2(WIDTH)
) (
    input  wire              clock,
    input  wire              reset,
    input  wire  [WIDTH-1:0] req,
    output logic [WIDTH-1:0] gnt
);

    logic [PTR_W-1:0] ptr;
    logic [PTR_W-1:0] winner;

    // first request at or after the pointer, wrapping around
    always_comb begin
        logic             found;
        logic [PTR_W-1:0] idx;
        found  = 1'b0;
        gnt    = '0;
        winner = ptr;
        for (int k = 0; k < WIDTH; k++) begin
            idx = ptr + PTR_W'(k);
            if (!found && req[idx]) begin
                found    = 1'b1;
                gnt[idx] = 1'b1;
                winner   = idx;
            end
        end
    end

    // winner gets lowest priority next time
    always_ff @(posedge clock) begin
        if (reset) begin
            ptr <= '0;
        end else if (gnt != '0) begin
            ptr <= winner + 1'b1;
        end
    end

    a_gnt_legal: assert property (@(posedge clock) disable iff (reset)
        $onehot0(gnt) && ((gnt & ~req) == '0));

endmodule

`default_nettype wire

// ==== rtl/lq_alloc.sv ====
`default_nettype none

module lq_alloc #(
    parameter  int LQ_SIZE = 8,
    parameter  int WAYS    = 2,
    localparam int WAY_W   = (WAYS > 1) ? $clog2(WAYS) : 1
) (
    input  wire  [LQ_SIZE-1:0]            free_mask,
    input  wire  [WAYS-1:0]               ld_en,
    output logic [LQ_SIZE-1:0]            entry_write,
    output logic [LQ_SIZE-1:0][WAY_W-1:0] entry_way
);

    // one-hot entry chosen by each way
    logic [WAYS-1:0][LQ_SIZE-1:0] way_gnt;

    // even ways scan up from entry 0, odd ways scan down from the top
    always_comb begin
        logic [LQ_SIZE-1:0] remaining;
        int                 e;
        remaining = free_mask;
        way_gnt   = '0;
        for (int w = 0; w < WAYS; w++) begin
            for (int k = 0; k < LQ_SIZE; k++) begin
                e = (w % 2 == 0) ? k : LQ_SIZE - 1 - k;
                if (ld_en[w] && remaining[e] && way_gnt[w] == '0) begin
                    way_gnt[w][e] = 1'b1;
                    remaining[e]  = 1'b0;
                end
            end
        end
    end

    // fold the per-way grants into per-entry strobes
    always_comb begin
        entry_write = '0;
        entry_way   = '0;
        for (int w = 0; w < WAYS; w++) begin
            for (int e = 0; e < LQ_SIZE; e++) begin
                if (way_gnt[w][e]) begin
                    entry_write[e] = 1'b1;
                    entry_way[e]   = WAY_W'(w);
                end
            end
        end
    end

    // two ways never land on the same entry
    always_comb begin
        for (int a = 0; a < WAYS; a++) begin
            for (int b = a + 1; b < WAYS; b++) begin
                assert ((way_gnt[a] & way_gnt[b]) == '0)
                    else $error("lq_alloc: ways %0d and %0d share an entry", a, b);
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/lq_order_check.sv ====
`default_nettype none

module lq_order_check #(
    parameter  int LQ_SIZE = 8,
    parameter  int SQ_SIZE = 8,
    localparam int SQ_W    = $clog2(SQ_SIZE)
) (
    input  wire                                      clock,
    input  wire                                      reset,
    input  wire                                      flush,
    input  wire  [LQ_SIZE-1:0]                       pending,
    input  wire  lq_pkg::mem_addr_t    [LQ_SIZE-1:0] ld_addr,
    input  wire  lq_pkg::access_size_t [LQ_SIZE-1:0] ld_size,
    input  wire  [LQ_SIZE-1:0][SQ_W-1:0]             ld_sq_tail,
    input  wire  [SQ_W-1:0]                          sq_head,
    input  wire  lq_pkg::mem_addr_t    [SQ_SIZE-1:0] store_addr,
    input  wire  lq_pkg::access_size_t [SQ_SIZE-1:0] store_size,
    input  wire  lq_pkg::word_t        [SQ_SIZE-1:0] store_data,
    input  wire  [SQ_SIZE-1:0]                       store_addr_valid,
    input  wire  [SQ_SIZE-1:0]                       store_data_valid,
    output logic [LQ_SIZE-1:0]                       fwd_hit,
    output lq_pkg::word_t              [LQ_SIZE-1:0] fwd_data,
    output logic [LQ_SIZE-1:0]                       ready_to_load
);

    import lq_pkg::*;

    // stores older than each load, [load][store slot]
    logic [LQ_SIZE-1:0][SQ_SIZE-1:0] older;
    logic [LQ_SIZE-1:0]              ready_next;

    // circular window from head up to the tail seen at dispatch
    always_comb begin
        for (int i = 0; i < LQ_SIZE; i++) begin
            for (int j = 0; j < SQ_SIZE; j++) begin
                if (sq_head > ld_sq_tail[i]) begin
                    older[i][j] = (SQ_W'(j) >= sq_head) || (SQ_W'(j) < ld_sq_tail[i]);
                end else begin
                    older[i][j] = (SQ_W'(j) >= sq_head) && (SQ_W'(j) < ld_sq_tail[i]);
                end
            end
        end
    end

    // walk back from the recorded tail, so the first block hit is the youngest
    always_comb begin
        logic            found;
        logic            full;
        logic            unknown;
        logic [SQ_W-1:0] slot;
        for (int i = 0; i < LQ_SIZE; i++) begin
            found       = 1'b0;
            full        = 1'b0;
            unknown     = 1'b0;
            fwd_data[i] = '0;
            for (int k = 0; k < SQ_SIZE; k++) begin
                slot = ld_sq_tail[i] - SQ_W'(k + 1);
                if (older[i][slot]) begin
                    if (!store_addr_valid[slot]) begin
                        unknown = 1'b1;
                    end else if (!found &&
                            store_addr[slot][offset_bits +: block_bits] ==
                            ld_addr[i][offset_bits +: block_bits]) begin
                        found = 1'b1;
                        full  = store_addr[slot][offset_bits-1:0] ==
                                ld_addr[i][offset_bits-1:0] &&
                                store_size[slot] == ld_size[i] &&
                                store_data_valid[slot];
                        fwd_data[i] = store_data[slot];
                    end
                end
            end
            // partial match or unresolved store address means wait
            fwd_hit[i]    = pending[i] && found && full && !unknown;
            ready_next[i] = pending[i] && !found && !unknown;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            ready_to_load <= '0;
        end else begin
            ready_to_load <= ready_next;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/lq_entries.sv ====
`default_nettype none

module lq_entries #(
    parameter  int LQ_SIZE = 8,
    parameter  int SQ_SIZE = 8,
    parameter  int WAYS    = 2,
    localparam int LQ_W    = $clog2(LQ_SIZE),
    localparam int SQ_W    = $clog2(SQ_SIZE),
    localparam int WAY_W   = (WAYS > 1) ? $clog2(WAYS) : 1,
    localparam int CNT_W   = $clog2(LQ_SIZE) + 1
) (
    input  wire                                      clock,
    input  wire                                      reset,
    input  wire                                      flush,
    // dispatch
    input  wire  [WAYS-1:0]                          ld_en,
    input  wire  lq_pkg::access_size_t [WAYS-1:0]    ld_size,
    input  wire  lq_pkg::rob_idx_t     [WAYS-1:0]    ld_rob_idx,
    input  wire  lq_pkg::prf_idx_t     [WAYS-1:0]    ld_prf_idx,
    input  wire  [WAYS-1:0][SQ_W-1:0]                ld_sq_tail,
    input  wire  [LQ_SIZE-1:0]                       entry_write,
    input  wire  [LQ_SIZE-1:0][WAY_W-1:0]            entry_way,
    // ALU result bus
    input  wire  [WAYS-1:0]                          alu_valid,
    input  wire  [WAYS-1:0]                          alu_is_mem,
    input  wire  lq_pkg::rob_idx_t     [WAYS-1:0]    alu_rob_idx,
    input  wire  lq_pkg::mem_addr_t    [WAYS-1:0]    alu_addr,
    // order check results
    input  wire  [LQ_SIZE-1:0]                       fwd_hit,
    input  wire  lq_pkg::word_t        [LQ_SIZE-1:0] fwd_data,
    input  wire  [LQ_SIZE-1:0]                       ready_to_load,
    // cache and memory returns
    input  wire                                      dc_hit,
    input  wire  lq_pkg::word_t                      dc_data,
    input  wire                                      mem_valid,
    input  wire  [LQ_W-1:0]                          mem_entry,
    input  wire  lq_pkg::word_t                      mem_data,
    // to allocation and order check
    output logic [LQ_SIZE-1:0]                       free_mask,
    output logic [LQ_SIZE-1:0]                       pending,
    output lq_pkg::mem_addr_t          [LQ_SIZE-1:0] entry_addr,
    output lq_pkg::access_size_t       [LQ_SIZE-1:0] entry_size,
    output logic [LQ_SIZE-1:0][SQ_W-1:0]             entry_sq_tail,
    // cache read
    output logic                                     rd_en,
    output lq_pkg::mem_addr_t                        rd_addr,
    output lq_pkg::access_size_t                     rd_size,
    output logic [LQ_W-1:0]                          rd_entry,
    // CDB
    output logic                                     cdb_valid,
    output lq_pkg::word_t                            cdb_data,
    output lq_pkg::prf_idx_t                         cdb_prf_idx,
    output lq_pkg::rob_idx_t                         cdb_rob_idx,
    output logic [CNT_W-1:0]                         lq_free_count
);

    import lq_pkg::*;

    // control state
    logic [LQ_SIZE-1:0] valid;
    logic [LQ_SIZE-1:0] addr_rdy;
    logic [LQ_SIZE-1:0] done;
    logic [LQ_SIZE-1:0] waiting;

    // payload
    rob_idx_t [LQ_SIZE-1:0] rob_idx;
    prf_idx_t [LQ_SIZE-1:0] prf_idx;
    word_t    [LQ_SIZE-1:0] data;

    logic      [LQ_SIZE-1:0] alu_hit;
    mem_addr_t [LQ_SIZE-1:0] alu_sel;
    logic      [LQ_SIZE-1:0] mem_fill;
    logic      [LQ_SIZE-1:0] rd_gnt;
    logic      [LQ_SIZE-1:0] cdb_gnt;
    logic      [LQ_SIZE-1:0] valid_next;
    logic      [CNT_W-1:0]   free_next;

    rr_arbiter #(.WIDTH(LQ_SIZE)) rd_arb (
        .clock (clock),
        .reset (reset),
        .req   (ready_to_load),
        .gnt   (rd_gnt)
    );

    rr_arbiter #(.WIDTH(LQ_SIZE)) cdb_arb (
        .clock (clock),
        .reset (reset),
        .req   (done),
        .gnt   (cdb_gnt)
    );

    assign free_mask  = ~valid;
    assign pending    = valid & addr_rdy & ~done & ~waiting & ~rd_gnt;
    assign valid_next = (valid & ~cdb_gnt) | entry_write;
    assign free_next  = CNT_W'(LQ_SIZE) - CNT_W'($countones(valid_next));

    // address capture by ROB index match on any ALU way
    always_comb begin
        alu_hit = '0;
        alu_sel = '0;
        for (int i = 0; i < LQ_SIZE; i++) begin
            for (int w = 0; w < WAYS; w++) begin
                if (valid[i] && !addr_rdy[i] && alu_valid[w] && alu_is_mem[w] &&
                        alu_rob_idx[w] == rob_idx[i]) begin
                    alu_hit[i] = 1'b1;
                    alu_sel[i] = alu_addr[w];
                end
            end
            mem_fill[i] = mem_valid && mem_entry == LQ_W'(i) && waiting[i];
        end
    end

    // granted entries onto the read and CDB ports
    always_comb begin
        rd_en       = 1'b0;
        rd_addr     = '0;
        rd_size     = size_byte;
        rd_entry    = '0;
        cdb_valid   = 1'b0;
        cdb_data    = '0;
        cdb_prf_idx = '0;
        cdb_rob_idx = '0;
        for (int i = 0; i < LQ_SIZE; i++) begin
            if (rd_gnt[i]) begin
                rd_en    = 1'b1;
                rd_addr  = entry_addr[i];
                rd_size  = entry_size[i];
                rd_entry = LQ_W'(i);
            end
            if (cdb_gnt[i]) begin
                cdb_valid   = 1'b1;
                cdb_data    = data[i];
                cdb_prf_idx = prf_idx[i];
                cdb_rob_idx = rob_idx[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            valid         <= '0;
            addr_rdy      <= '0;
            done          <= '0;
            waiting       <= '0;
            lq_free_count <= CNT_W'(LQ_SIZE);
        end else begin
            valid <= valid_next;
            for (int i = 0; i < LQ_SIZE; i++) begin
                if (cdb_gnt[i] || entry_write[i]) begin
                    addr_rdy[i] <= 1'b0;
                    done[i]     <= 1'b0;
                    waiting[i]  <= 1'b0;
                end else begin
                    if (alu_hit[i]) begin
                        addr_rdy[i] <= 1'b1;
                    end
                    if (fwd_hit[i] || (rd_gnt[i] && dc_hit) || mem_fill[i]) begin
                        done[i] <= 1'b1;
                    end
                    // miss parks the entry until memory answers
                    if (rd_gnt[i] && !dc_hit) begin
                        waiting[i] <= 1'b1;
                    end else if (mem_fill[i]) begin
                        waiting[i] <= 1'b0;
                    end
                end
            end
            // dispatch side sees 0 unless a full group of ways fits
            lq_free_count <= (free_next < CNT_W'(WAYS)) ? '0 : free_next;
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < LQ_SIZE; i++) begin
            if (entry_write[i]) begin
                entry_size[i]    <= ld_size[entry_way[i]];
                rob_idx[i]       <= ld_rob_idx[entry_way[i]];
                prf_idx[i]       <= ld_prf_idx[entry_way[i]];
                entry_sq_tail[i] <= ld_sq_tail[entry_way[i]];
            end
            if (alu_hit[i]) begin
                entry_addr[i] <= alu_sel[i];
            end
            if (fwd_hit[i]) begin
                data[i] <= fwd_data[i];
            end else if (rd_gnt[i] && dc_hit) begin
                data[i] <= dc_data;
            end else if (mem_fill[i]) begin
                data[i] <= mem_data;
            end
        end
    end

    a_mem_waiting: assert property (@(posedge clock) disable iff (reset || flush)
        mem_valid |-> waiting[mem_entry]);

    // every enabled way must find a slot when the free count allowed it
    a_dispatch_placed: assert property (@(posedge clock) disable iff (reset || flush)
        $countones(entry_write) == $countones(ld_en));

endmodule

`default_nettype wire

// ==== rtl/load_queue.sv ====
`default_nettype none

module load_queue #(
    parameter  int LQ_SIZE = lq_pkg::lq_size_default,
    parameter  int SQ_SIZE = lq_pkg::sq_size_default,
    parameter  int WAYS    = lq_pkg::ways_default,
    localparam int LQ_W    = $clog2(LQ_SIZE),
    localparam int SQ_W    = $clog2(SQ_SIZE),
    localparam int WAY_W   = (WAYS > 1) ? $clog2(WAYS) : 1,
    localparam int CNT_W   = $clog2(LQ_SIZE) + 1
) (
    input  wire                                      clock,
    input  wire                                      reset,
    input  wire                                      except,
    input  wire  [WAYS-1:0]                          ld_en,
    input  wire  lq_pkg::access_size_t [WAYS-1:0]    ld_size,
    input  wire  lq_pkg::rob_idx_t     [WAYS-1:0]    ld_rob_idx,
    input  wire  lq_pkg::prf_idx_t     [WAYS-1:0]    ld_prf_idx,
    input  wire  [WAYS-1:0][SQ_W-1:0]                ld_sq_tail,
    input  wire  [WAYS-1:0]                          alu_valid,
    input  wire  [WAYS-1:0]                          alu_is_mem,
    input  wire  lq_pkg::rob_idx_t     [WAYS-1:0]    alu_rob_idx,
    input  wire  lq_pkg::mem_addr_t    [WAYS-1:0]    alu_addr,
    input  wire  lq_pkg::mem_addr_t    [SQ_SIZE-1:0] store_addr,
    input  wire  lq_pkg::access_size_t [SQ_SIZE-1:0] store_size,
    input  wire  lq_pkg::word_t        [SQ_SIZE-1:0] store_data,
    input  wire  [SQ_SIZE-1:0]                       store_addr_valid,
    input  wire  [SQ_SIZE-1:0]                       store_data_valid,
    input  wire  [SQ_W-1:0]                          sq_head,
    input  wire                                      dc_hit,
    input  wire  lq_pkg::word_t                      dc_data,
    input  wire                                      mem_valid,
    input  wire  [LQ_W-1:0]                          mem_entry,
    input  wire  lq_pkg::word_t                      mem_data,
    output logic [CNT_W-1:0]                         lq_free_count,
    output logic                                     rd_en,
    output lq_pkg::mem_addr_t                        rd_addr,
    output lq_pkg::access_size_t                     rd_size,
    output logic [LQ_W-1:0]                          rd_entry,
    output logic                                     cdb_valid,
    output lq_pkg::word_t                            cdb_data,
    output lq_pkg::prf_idx_t                         cdb_prf_idx,
    output lq_pkg::rob_idx_t                         cdb_rob_idx
);

    import lq_pkg::*;

    logic         [LQ_SIZE-1:0]            free_mask;
    logic         [LQ_SIZE-1:0]            pending;
    logic         [LQ_SIZE-1:0]            entry_write;
    logic         [LQ_SIZE-1:0][WAY_W-1:0] entry_way;
    mem_addr_t    [LQ_SIZE-1:0]            entry_addr;
    access_size_t [LQ_SIZE-1:0]            entry_size;
    logic         [LQ_SIZE-1:0][SQ_W-1:0]  entry_sq_tail;
    logic         [LQ_SIZE-1:0]            fwd_hit;
    word_t        [LQ_SIZE-1:0]            fwd_data;
    logic         [LQ_SIZE-1:0]            ready_to_load;

    lq_alloc #(.LQ_SIZE(LQ_SIZE), .WAYS(WAYS)) alloc (
        .free_mask   (free_mask),
        .ld_en       (ld_en),
        .entry_write (entry_write),
        .entry_way   (entry_way)
    );

    lq_order_check #(.LQ_SIZE(LQ_SIZE), .SQ_SIZE(SQ_SIZE)) order_check (
        .clock            (clock),
        .reset            (reset),
        .flush            (except),
        .pending          (pending),
        .ld_addr          (entry_addr),
        .ld_size          (entry_size),
        .ld_sq_tail       (entry_sq_tail),
        .sq_head          (sq_head),
        .store_addr       (store_addr),
        .store_size       (store_size),
        .store_data       (store_data),
        .store_addr_valid (store_addr_valid),
        .store_data_valid (store_data_valid),
        .fwd_hit          (fwd_hit),
        .fwd_data         (fwd_data),
        .ready_to_load    (ready_to_load)
    );

    lq_entries #(.LQ_SIZE(LQ_SIZE), .SQ_SIZE(SQ_SIZE), .WAYS(WAYS)) entries (
        .clock         (clock),
        .reset         (reset),
        .flush         (except),
        .ld_en         (ld_en),
        .ld_size       (ld_size),
        .ld_rob_idx    (ld_rob_idx),
        .ld_prf_idx    (ld_prf_idx),
        .ld_sq_tail    (ld_sq_tail),
        .entry_write   (entry_write),
        .entry_way     (entry_way),
        .alu_valid     (alu_valid),
        .alu_is_mem    (alu_is_mem),
        .alu_rob_idx   (alu_rob_idx),
        .alu_addr      (alu_addr),
        .fwd_hit       (fwd_hit),
        .fwd_data      (fwd_data),
        .ready_to_load (ready_to_load),
        .dc_hit        (dc_hit),
        .dc_data       (dc_data),
        .mem_valid     (mem_valid),
        .mem_entry     (mem_entry),
        .mem_data      (mem_data),
        .free_mask     (free_mask),
        .pending       (pending),
        .entry_addr    (entry_addr),
        .entry_size    (entry_size),
        .entry_sq_tail (entry_sq_tail),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_size       (rd_size),
        .rd_entry      (rd_entry),
        .cdb_valid     (cdb_valid),
        .cdb_data      (cdb_data),
        .cdb_prf_idx   (cdb_prf_idx),
        .cdb_rob_idx   (cdb_rob_idx),
        .lq_free_count (lq_free_count)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_load_tests.svh ====
`ifndef TB_LOAD_TESTS_SVH
`define TB_LOAD_TESTS_SVH

// move to the next falling edge and drop one-cycle strobes
task automatic next_cycle();
    @(negedge clock);
    ld_en = '0;
    alu_valid = '0;
    alu_is_mem = '0;
    mem_valid = 1'b0;
    except = 1'b0;
endtask

task automatic check_value(input string name, input logic [31:0] expected, actual);
    assert (expected == actual)
        else begin
            $display("FAILED at %0t: %s expected %0h got %0h", $time, name, expected, actual);
            errors++;
        end
endtask

// drive one way of dispatch and note what its broadcast must carry
task automatic dispatch_load(input int way, input rob_idx_t rob, input prf_idx_t prf,
        input logic [2:0] tail, input int entry, input mem_addr_t addr, input logic live);
    ld_en[way] = 1'b1;
    ld_size[way] = size_word;
    ld_rob_idx[way] = rob;
    ld_prf_idx[way] = prf;
    ld_sq_tail[way] = tail;
    exp_prf[rob] = prf;
    exp_live[rob] = live;
    exp_addr[entry] = addr;
    exp_size[entry] = size_word;
endtask

task automatic send_addr(input int way, input rob_idx_t rob, input mem_addr_t addr);
    alu_valid[way] = 1'b1;
    alu_is_mem[way] = 1'b1;
    alu_rob_idx[way] = rob;
    alu_addr[way] = addr;
endtask

task automatic wait_cdb(input rob_idx_t rob);
    int n;
    n = 0;
    while (seen[rob] == 0 && n < 100) begin
        next_cycle();
        n++;
    end
    if (seen[rob] == 0) begin
        $display("no broadcast for rob %0d within 100 cycles", rob);
        errors++;
    end
endtask

task automatic end_test(input int num, input string name, input int errors_before);
    if (errors == errors_before) begin
        tests_ok++;
        $display("test %0d %s: ok", num, name);
    end else begin
        $display("test %0d %s: FAILED", num, name);
    end
endtask

task automatic run_tests();
    int e0;
    int n;
    // reset values, then two loads in one cycle
    e0 = errors;
    check_value("lq_free_count", 8, lq_free_count);
    check_value("rd_en", 0, rd_en);
    check_value("cdb_valid", 0, cdb_valid);
    dispatch_load(0, 5'd1, 6'd11, 3'd0, 0, 16'h0010, 1'b1);
    dispatch_load(1, 5'd2, 6'd12, 3'd0, 7, 16'h0020, 1'b1);
    // second way reads a halfword
    ld_size[1] = size_half;
    exp_size[7] = size_half;
    next_cycle();
    check_value("lq_free_count", 6, lq_free_count);
    end_test(1, "reset and dispatch", e0);

    // both loads hit the cache
    e0 = errors;
    dc_hit = 1'b1;
    dc_data = $urandom;
    exp_data[1] = dc_data;
    exp_data[2] = dc_data;
    send_addr(0, 5'd1, 16'h0010);
    send_addr(1, 5'd2, 16'h0020);
    next_cycle();
    wait_cdb(5'd1);
    wait_cdb(5'd2);
    end_test(2, "cache hit", e0);

    // store in slot 0 forwards to the load
    e0 = errors;
    dc_hit = 1'b0;
    store_addr[0] = 16'h0240;
    store_data[0] = $urandom;
    store_addr_valid[0] = 1'b1;
    store_data_valid[0] = 1'b1;
    exp_data[3] = store_data[0];
    no_read[0] = 1'b1;
    dispatch_load(0, 5'd3, 6'd13, 3'd1, 0, 16'h0240, 1'b1);
    next_cycle();
    send_addr(0, 5'd3, 16'h0240);
    next_cycle();
    wait_cdb(5'd3);
    repeat (4) next_cycle();
    no_read[0] = 1'b0;
    end_test(3, "forwarding", e0);

    // partial overlap in slot 1 stalls, slot 5 lies outside the window
    e0 = errors;
    sq_head = 3'd1;
    store_addr[1] = 16'h0104;
    store_data[1] = $urandom;
    store_addr[5] = 16'h0100;
    store_data[5] = $urandom;
    store_addr_valid[1] = 1'b1;
    store_data_valid[1] = 1'b1;
    store_addr_valid[5] = 1'b1;
    store_data_valid[5] = 1'b1;
    dc_hit = 1'b1;
    dc_data = $urandom;
    exp_data[4] = dc_data;
    no_read[0] = 1'b1;
    dispatch_load(0, 5'd4, 6'd14, 3'd2, 0, 16'h0100, 1'b1);
    next_cycle();
    send_addr(0, 5'd4, 16'h0100);
    repeat (10) next_cycle();
    no_read[0] = 1'b0;
    sq_head = 3'd2;
    wait_cdb(5'd4);
    end_test(4, "stall", e0);

    // miss, then a memory return fills the entry
    e0 = errors;
    dc_hit = 1'b0;
    dispatch_load(0, 5'd5, 6'd15, 3'd2, 0, 16'h0300, 1'b1);
    next_cycle();
    send_addr(0, 5'd5, 16'h0300);
    n = 0;
    while (!rd_en && n < 50) begin
        next_cycle();
        n++;
    end
    if (!rd_en) begin
        $display("miss load never issued a cache read");
        errors++;
    end
    check_value("rd_entry", 0, rd_entry);
    repeat (3) next_cycle();
    mem_valid = 1'b1;
    mem_entry = 3'd0;
    mem_data = $urandom;
    exp_data[5] = mem_data;
    next_cycle();
    wait_cdb(5'd5);
    end_test(5, "miss", e0);

    // fill the queue until the free count clamps, then flush
    e0 = errors;
    repeat (2) next_cycle();
    dispatch_load(0, 5'd7, 6'd17, 3'd2, 0, 16'h0400, 1'b0);
    dispatch_load(1, 5'd8, 6'd18, 3'd2, 7, 16'h0408, 1'b0);
    next_cycle();
    check_value("lq_free_count", 6, lq_free_count);
    send_addr(0, 5'd7, 16'h0400);
    dispatch_load(0, 5'd9, 6'd19, 3'd2, 1, 16'h0410, 1'b0);
    dispatch_load(1, 5'd10, 6'd20, 3'd2, 6, 16'h0418, 1'b0);
    next_cycle();
    check_value("lq_free_count", 4, lq_free_count);
    dispatch_load(0, 5'd11, 6'd21, 3'd2, 2, 16'h0420, 1'b0);
    dispatch_load(1, 5'd12, 6'd22, 3'd2, 5, 16'h0428, 1'b0);
    next_cycle();
    check_value("lq_free_count", 2, lq_free_count);
    // one free entry is fewer than a dispatch group
    dispatch_load(0, 5'd13, 6'd23, 3'd2, 3, 16'h0430, 1'b0);
    next_cycle();
    check_value("lq_free_count", 0, lq_free_count);
    repeat (4) next_cycle();
    except = 1'b1;
    next_cycle();
    check_value("lq_free_count", 8, lq_free_count);
    // a late address with a hit would broadcast any load left behind
    no_read = '1;
    dc_hit = 1'b1;
    send_addr(1, 5'd8, 16'h0408);
    repeat (20) next_cycle();
    check_value("lq_free_count", 8, lq_free_count);
    end_test(6, "flush", e0);
endtask

`endif

// ==== testbench/tb_load_queue.sv ====
`default_nettype none

module tb_load_queue;

    import lq_pkg::*;

    localparam int LQ_SIZE = 8;
    localparam int SQ_SIZE = 8;
    localparam int WAYS    = 2;
    localparam int N_TESTS = 6;

    logic clock;
    logic reset;
    logic except;

    logic         [WAYS-1:0]            ld_en;
    access_size_t [WAYS-1:0]            ld_size;
    rob_idx_t     [WAYS-1:0]            ld_rob_idx;
    prf_idx_t     [WAYS-1:0]            ld_prf_idx;
    logic         [WAYS-1:0][2:0]       ld_sq_tail;
    logic         [WAYS-1:0]            alu_valid;
    logic         [WAYS-1:0]            alu_is_mem;
    rob_idx_t     [WAYS-1:0]            alu_rob_idx;
    mem_addr_t    [WAYS-1:0]            alu_addr;

    // store queue model, one slot per array element
    mem_addr_t    [SQ_SIZE-1:0] store_addr;
    access_size_t [SQ_SIZE-1:0] store_size;
    word_t        [SQ_SIZE-1:0] store_data;
    logic         [SQ_SIZE-1:0] store_addr_valid;
    logic         [SQ_SIZE-1:0] store_data_valid;
    logic         [2:0]         sq_head;

    logic         dc_hit;
    word_t        dc_data;
    logic         mem_valid;
    logic [2:0]   mem_entry;
    word_t        mem_data;

    logic [3:0]   lq_free_count;
    logic         rd_en;
    mem_addr_t    rd_addr;
    access_size_t rd_size;
    logic [2:0]   rd_entry;
    logic         cdb_valid;
    word_t        cdb_data;
    prf_idx_t     cdb_prf_idx;
    rob_idx_t     cdb_rob_idx;

    // expected results per ROB index and per entry
    logic     [31:0]      exp_live;
    word_t                exp_data [32];
    prf_idx_t             exp_prf [32];
    int                   seen [32];
    mem_addr_t            exp_addr [LQ_SIZE];
    access_size_t         exp_size [LQ_SIZE];
    logic [LQ_SIZE-1:0]   no_read;

    int errors;
    int tests_ok;

    load_queue #(.LQ_SIZE(LQ_SIZE), .SQ_SIZE(SQ_SIZE), .WAYS(WAYS)) dut0 (.*);

    always #2 clock = ~clock;

    always @(posedge clock) begin
        if (!reset && cdb_valid) begin
            seen[cdb_rob_idx] <= seen[cdb_rob_idx] + 1;
        end
    end

    a_cdb_expected: assert property (@(posedge clock) disable iff (reset)
        cdb_valid |-> exp_live[cdb_rob_idx] && seen[cdb_rob_idx] == 0)
        else begin
            $display("broadcast at %0t for rob %0d that was not expected or came twice",
                $time, $sampled(cdb_rob_idx));
            errors++;
        end

    a_cdb_data: assert property (@(posedge clock) disable iff (reset)
        cdb_valid |-> cdb_data == exp_data[cdb_rob_idx])
        else begin
            $display("FAILED at %0t: cdb_data expected %h got %h", $time,
                exp_data[$sampled(cdb_rob_idx)], $sampled(cdb_data));
            errors++;
        end

    a_cdb_prf: assert property (@(posedge clock) disable iff (reset)
        cdb_valid |-> cdb_prf_idx == exp_prf[cdb_rob_idx])
        else begin
            $display("FAILED at %0t: cdb_prf_idx expected %0d got %0d", $time,
                exp_prf[$sampled(cdb_rob_idx)], $sampled(cdb_prf_idx));
            errors++;
        end

    a_rd_allowed: assert property (@(posedge clock) disable iff (reset)
        rd_en |-> !no_read[rd_entry])
        else begin
            $display("cache read at %0t for entry %0d that must not read yet",
                $time, $sampled(rd_entry));
            errors++;
        end

    a_rd_addr: assert property (@(posedge clock) disable iff (reset)
        rd_en |-> rd_addr == exp_addr[rd_entry])
        else begin
            $display("FAILED at %0t: rd_addr expected %h got %h", $time,
                exp_addr[$sampled(rd_entry)], $sampled(rd_addr));
            errors++;
        end

    a_rd_size: assert property (@(posedge clock) disable iff (reset)
        rd_en |-> rd_size == exp_size[rd_entry])
        else begin
            $display("FAILED at %0t: rd_size expected %0d got %0d", $time,
                exp_size[$sampled(rd_entry)], $sampled(rd_size));
            errors++;
        end

    `include "tb_load_tests.svh"

    // six tests at most 200 cycles each
    initial begin
        #(N_TESTS * 200 * 4);
        $display("watchdog expired before the tests completed");
        $display("tests failed");
        $finish;
    end

    initial begin
        void'($urandom(2));
        clock = 1'b0;
        reset = 1'b1;
        except = 1'b0;
        ld_en = '0;
        ld_size = '{default: size_word};
        ld_rob_idx = '0;
        ld_prf_idx = '0;
        ld_sq_tail = '0;
        alu_valid = '0;
        alu_is_mem = '0;
        alu_rob_idx = '0;
        alu_addr = '0;
        store_addr = '0;
        store_size = '{default: size_word};
        store_data = '0;
        store_addr_valid = '0;
        store_data_valid = '0;
        sq_head = '0;
        dc_hit = 1'b0;
        dc_data = '0;
        mem_valid = 1'b0;
        mem_entry = '0;
        mem_data = '0;
        exp_live = '0;
        no_read = '0;
        errors = 0;
        tests_ok = 0;
        for (int r = 0; r < 32; r++) begin
            seen[r] = 0;
            exp_data[r] = '0;
            exp_prf[r] = '0;
        end
        for (int e = 0; e < LQ_SIZE; e++) begin
            exp_addr[e] = '0;
            exp_size[e] = size_word;
        end
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        run_tests();
        $display("%0d tests, %0d ok, %0d failed, %0d errors", N_TESTS, tests_ok,
            N_TESTS - tests_ok, errors);
        if (errors == 0 && tests_ok == N_TESTS) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+testbench
rtl/lq_pkg.sv
rtl/rr_arbiter.sv
rtl/lq_alloc.sv
rtl/lq_order_check.sv
rtl/lq_entries.sv
rtl/load_queue.sv
testbench/tb_load_queue.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the load queue testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --Wno-fatal -f flist.f \
    --top-module tb_load_queue -o sim_load_queue \
    && ./obj_dir/sim_load_queue > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "all tests passed" sim.log \
    && echo "simulation PASS" \
    || { echo "simulation FAIL"; exit 1; }
